//--- include/csr_settings.svh
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// architectural data width
`define CSR_XLEN 32

// machine trap setup and handling
`define CSR_ADDR_MTVEC     12'h305
`define CSR_ADDR_MSCRATCH  12'h340
`define CSR_ADDR_MEPC      12'h341
`define CSR_ADDR_MCAUSE    12'h342
`define CSR_ADDR_MTVAL     12'h343

// machine counters with the high halves at +0x80
`define CSR_ADDR_MCYCLE    12'hb00
`define CSR_ADDR_MINSTRET  12'hb02
`define CSR_ADDR_MCYCLEH   12'hb80
`define CSR_ADDR_MINSTRETH 12'hb82

`endif

//--- verilog/csr_pkg.sv
`include "csr_settings.svh"

package csr_pkg;

  //////////////////////////////
  // basic widths
  //////////////////////////////

  typedef logic [`CSR_XLEN-1:0] xlen_t;
  typedef logic [11:0]          csr_addr_t;
  // register index that doubles as the 5-bit immediate of the i forms
  typedef logic [4:0]           reg_idx_t;
  // exception code below the interrupt flag at the top of mcause
  typedef logic [`CSR_XLEN-2:0] cause_t;

  //////////////////////////////
  // instruction encoding
  //////////////////////////////

  // values follow funct3 of the SYSTEM opcode
  typedef enum logic [2:0] {
    CSR_RW  = 3'd1,
    CSR_RS  = 3'd2,
    CSR_RC  = 3'd3,
    CSR_RWI = 3'd5,
    CSR_RSI = 3'd6,
    CSR_RCI = 3'd7
  } csr_op_e;

  // trap carried down the pipe with the instruction
  typedef struct packed {
    logic   valid;
    logic   is_interrupt;
    cause_t mcause;
    xlen_t  pc;
  } trap_info_t;

endpackage

//--- verilog/csr_ifs.sv
`timescale 1ns/1ps

// decode stage read port
interface csr_rd_if;
  import csr_pkg::*;

  csr_addr_t raddr;
  xlen_t     rdata;
  // in-flight flags for the minstret read correction
  logic      ex_valid;
  logic      mem_valid;

  modport regfile (
    input  raddr,
    input  ex_valid,
    input  mem_valid,
    output rdata
  );

  modport pipe (
    output raddr,
    output ex_valid,
    output mem_valid,
    input  rdata
  );
endinterface

// write-back port where a waddr of 0 means no csr write
interface csr_wb_if;
  import csr_pkg::*;

  logic       valid;
  reg_idx_t   rd_addr;
  csr_addr_t  waddr;
  xlen_t      wdata;
  trap_info_t trap;
  xlen_t      rmask;

  modport regfile (
    input  valid,
    input  rd_addr,
    input  waddr,
    input  wdata,
    input  trap,
    output rmask
  );

  modport writeback (
    output valid,
    output rd_addr,
    output waddr,
    output wdata,
    output trap,
    input  rmask
  );
endinterface

//--- verilog/csr_regfile.sv
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_regfile (
  input  logic            clk_i,
  input  logic            rst_i,
  csr_rd_if.regfile       rd_port,
  csr_wb_if.regfile       wb_port,
  output csr_pkg::xlen_t  trap_handler_addr_o
);
  import csr_pkg::*;

  xlen_t       mtvec_q;
  xlen_t       mscratch_q;
  xlen_t       mepc_q;
  xlen_t       mcause_q;
  xlen_t       mtval_q;
  logic [63:0] mcycle_q;
  logic [63:0] minstret_q;

  xlen_t       mtvec_d;
  xlen_t       mscratch_d;
  xlen_t       mepc_d;
  xlen_t       mcause_d;
  xlen_t       mtval_d;

  logic        trap_take;
  xlen_t       inflight_cnt;

  //////////////////////////////
  // read port
  //////////////////////////////

  // instructions already past issue retire before this one
  assign inflight_cnt = xlen_t'(rd_port.ex_valid) + xlen_t'(rd_port.mem_valid)
                      + xlen_t'(wb_port.valid);

  always_comb begin
    rd_port.rdata = '0;
    case (rd_port.raddr)
      `CSR_ADDR_MTVEC:     rd_port.rdata = mtvec_q;
      `CSR_ADDR_MSCRATCH:  rd_port.rdata = mscratch_q;
      `CSR_ADDR_MEPC:      rd_port.rdata = mepc_q;
      `CSR_ADDR_MCAUSE:    rd_port.rdata = mcause_q;
      `CSR_ADDR_MTVAL:     rd_port.rdata = mtval_q;
      `CSR_ADDR_MCYCLE:    rd_port.rdata = mcycle_q[31:0];
      `CSR_ADDR_MCYCLEH:   rd_port.rdata = mcycle_q[63:32];
      `CSR_ADDR_MINSTRET:  rd_port.rdata = minstret_q[31:0] + inflight_cnt;
      `CSR_ADDR_MINSTRETH: rd_port.rdata = minstret_q[63:32];
      default:             rd_port.rdata = '0;
    endcase
  end

  //////////////////////////////
  // write port and traps
  //////////////////////////////

  assign trap_take = wb_port.valid && wb_port.trap.valid;

  always_comb begin
    mtvec_d    = mtvec_q;
    mscratch_d = mscratch_q;
    mtval_d    = mtval_q;
    // a trapping instruction never carries a write address
    mepc_d     = trap_take ? wb_port.trap.pc : mepc_q;
    mcause_d   = trap_take ? {wb_port.trap.is_interrupt, wb_port.trap.mcause} : mcause_q;

    case (wb_port.waddr)
      `CSR_ADDR_MTVEC:    mtvec_d    = {wb_port.wdata[31:2], 2'b00};
      `CSR_ADDR_MSCRATCH: mscratch_d = wb_port.wdata;
      `CSR_ADDR_MEPC:     mepc_d     = wb_port.wdata;
      `CSR_ADDR_MCAUSE:   mcause_d   = wb_port.wdata;
      `CSR_ADDR_MTVAL:    mtval_d    = wb_port.wdata;
      // counters are read only so their writes fall through here
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
    end else begin
      mtvec_q    <= mtvec_d;
      mscratch_q <= mscratch_d;
      mepc_q     <= mepc_d;
      mcause_q   <= mcause_d;
      mtval_q    <= mtval_d;
    end
  end

  //////////////////////////////
  // counters
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mcycle_q   <= '0;
      minstret_q <= '0;
    end else begin
      mcycle_q <= mcycle_q + 64'd1;
      // every retiring instruction counts even when it traps
      if (wb_port.valid) begin
        minstret_q <= minstret_q + 64'd1;
      end
    end
  end

  //////////////////////////////
  // trap handler address
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      trap_handler_addr_o <= '0;
    end else begin
      trap_handler_addr_o <= {mtvec_q[31:2], 2'b00};
    end
  end

  // x0 destinations get nothing back
  assign wb_port.rmask = (wb_port.rd_addr != '0) ? '1 : '0;

endmodule

//--- verilog/csr_pipe.sv
`timescale 1ns/1ps

module csr_pipe (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 issue_valid_i,
  input  csr_pkg::csr_op_e     issue_op_i,
  input  csr_pkg::csr_addr_t   issue_addr_i,
  input  csr_pkg::reg_idx_t    issue_rd_i,
  input  csr_pkg::reg_idx_t    issue_rs1_i,
  input  csr_pkg::xlen_t       issue_rs1_val_i,
  input  csr_pkg::trap_info_t  issue_trap_i,
  csr_rd_if.pipe               rd_port,
  output logic                 wb_valid_o,
  output csr_pkg::csr_op_e     wb_op_o,
  output csr_pkg::csr_addr_t   wb_addr_o,
  output csr_pkg::reg_idx_t    wb_rd_o,
  output csr_pkg::reg_idx_t    wb_rs1_o,
  output csr_pkg::xlen_t       wb_rs1_val_o,
  output csr_pkg::xlen_t       wb_old_o,
  output csr_pkg::trap_info_t  wb_trap_o
);
  import csr_pkg::*;

  logic       ex_valid_q,   mem_valid_q;
  csr_op_e    ex_op_q,      mem_op_q;
  csr_addr_t  ex_addr_q,    mem_addr_q;
  reg_idx_t   ex_rd_q,      mem_rd_q;
  reg_idx_t   ex_rs1_q,     mem_rs1_q;
  xlen_t      ex_rs1_val_q, mem_rs1_val_q;
  xlen_t      ex_old_q,     mem_old_q;
  trap_info_t ex_trap_q,    mem_trap_q;

  // the old value is read in the issue cycle
  assign rd_port.raddr     = issue_addr_i;
  assign rd_port.ex_valid  = ex_valid_q;
  assign rd_port.mem_valid = mem_valid_q;

  //////////////////////////////
  // valid bits
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ex_valid_q  <= 1'b0;
      mem_valid_q <= 1'b0;
      wb_valid_o  <= 1'b0;
    end else begin
      ex_valid_q  <= issue_valid_i;
      mem_valid_q <= ex_valid_q;
      wb_valid_o  <= mem_valid_q;
    end
  end

  //////////////////////////////
  // payload shift
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    // issue -> execute
    ex_op_q       <= issue_op_i;
    ex_addr_q     <= issue_addr_i;
    ex_rd_q       <= issue_rd_i;
    ex_rs1_q      <= issue_rs1_i;
    ex_rs1_val_q  <= issue_rs1_val_i;
    ex_old_q      <= rd_port.rdata;
    ex_trap_q     <= issue_trap_i;
    // execute -> memory
    mem_op_q      <= ex_op_q;
    mem_addr_q    <= ex_addr_q;
    mem_rd_q      <= ex_rd_q;
    mem_rs1_q     <= ex_rs1_q;
    mem_rs1_val_q <= ex_rs1_val_q;
    mem_old_q     <= ex_old_q;
    mem_trap_q    <= ex_trap_q;
    // memory -> write-back
    wb_op_o       <= mem_op_q;
    wb_addr_o     <= mem_addr_q;
    wb_rd_o       <= mem_rd_q;
    wb_rs1_o      <= mem_rs1_q;
    wb_rs1_val_o  <= mem_rs1_val_q;
    wb_old_o      <= mem_old_q;
    wb_trap_o     <= mem_trap_q;
  end

endmodule

//--- verilog/csr_writeback.sv
`timescale 1ns/1ps

module csr_writeback (
  input  logic                 wb_valid_i,
  input  csr_pkg::csr_op_e     wb_op_i,
  input  csr_pkg::csr_addr_t   wb_addr_i,
  input  csr_pkg::reg_idx_t    wb_rd_i,
  input  csr_pkg::reg_idx_t    wb_rs1_i,
  input  csr_pkg::xlen_t       wb_rs1_val_i,
  input  csr_pkg::xlen_t       wb_old_i,
  input  csr_pkg::trap_info_t  wb_trap_i,
  csr_wb_if.writeback          wb_port,
  output logic                 rd_we_o,
  output csr_pkg::reg_idx_t    rd_addr_o,
  output csr_pkg::xlen_t       rd_wdata_o
);
  import csr_pkg::*;

  xlen_t src;
  xlen_t new_val;
  logic  is_set_clr;
  logic  do_write;

  //////////////////////////////
  // new value
  //////////////////////////////

  // immediate forms use the rs1 field as a zero-extended operand
  always_comb begin
    case (wb_op_i)
      CSR_RWI, CSR_RSI, CSR_RCI: src = xlen_t'(wb_rs1_i);
      default:                   src = wb_rs1_val_i;
    endcase
  end

  always_comb begin
    case (wb_op_i)
      CSR_RS, CSR_RSI: new_val = wb_old_i | src;
      CSR_RC, CSR_RCI: new_val = wb_old_i & ~src;
      default:         new_val = src;
    endcase
  end

  // set or clear with x0 / zero immediate only reads
  assign is_set_clr = (wb_op_i == CSR_RS) || (wb_op_i == CSR_RSI)
                   || (wb_op_i == CSR_RC) || (wb_op_i == CSR_RCI);

  assign do_write = wb_valid_i && !wb_trap_i.valid && !(is_set_clr && (wb_rs1_i == '0));

  //////////////////////////////
  // write-back port
  //////////////////////////////

  assign wb_port.valid   = wb_valid_i;
  assign wb_port.rd_addr = wb_rd_i;
  assign wb_port.waddr   = do_write ? wb_addr_i : '0;
  assign wb_port.wdata   = new_val;
  assign wb_port.trap    = wb_trap_i;

  // integer register file result
  assign rd_we_o    = wb_valid_i && !wb_trap_i.valid;
  assign rd_addr_o  = wb_rd_i;
  assign rd_wdata_o = wb_old_i & wb_port.rmask;

endmodule

//--- verilog/csr_subsys_top.sv
`timescale 1ns/1ps

module csr_subsys_top (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                issue_valid_i,
  input  csr_pkg::csr_op_e    issue_op_i,
  input  csr_pkg::csr_addr_t  issue_addr_i,
  input  csr_pkg::reg_idx_t   issue_rd_i,
  input  csr_pkg::reg_idx_t   issue_rs1_i,
  input  csr_pkg::xlen_t      issue_rs1_val_i,
  input  logic                issue_trap_valid_i,
  input  logic                issue_trap_irq_i,
  input  csr_pkg::cause_t     issue_trap_cause_i,
  input  csr_pkg::xlen_t      issue_trap_pc_i,
  output logic                rd_we_o,
  output csr_pkg::reg_idx_t   rd_addr_o,
  output csr_pkg::xlen_t      rd_wdata_o,
  output csr_pkg::xlen_t      trap_handler_addr_o
);
  import csr_pkg::*;

  trap_info_t issue_trap;

  // write-back stage between pipe and writeback
  logic       wb_valid;
  csr_op_e    wb_op;
  csr_addr_t  wb_addr;
  reg_idx_t   wb_rd;
  reg_idx_t   wb_rs1;
  xlen_t      wb_rs1_val;
  xlen_t      wb_old;
  trap_info_t wb_trap;

  csr_rd_if u_rd_if ();
  csr_wb_if u_wb_if ();

  assign issue_trap.valid        = issue_trap_valid_i;
  assign issue_trap.is_interrupt = issue_trap_irq_i;
  assign issue_trap.mcause       = issue_trap_cause_i;
  assign issue_trap.pc           = issue_trap_pc_i;

  csr_pipe u_csr_pipe (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .issue_valid_i   (issue_valid_i),
    .issue_op_i      (issue_op_i),
    .issue_addr_i    (issue_addr_i),
    .issue_rd_i      (issue_rd_i),
    .issue_rs1_i     (issue_rs1_i),
    .issue_rs1_val_i (issue_rs1_val_i),
    .issue_trap_i    (issue_trap),
    .rd_port         (u_rd_if.pipe),
    .wb_valid_o      (wb_valid),
    .wb_op_o         (wb_op),
    .wb_addr_o       (wb_addr),
    .wb_rd_o         (wb_rd),
    .wb_rs1_o        (wb_rs1),
    .wb_rs1_val_o    (wb_rs1_val),
    .wb_old_o        (wb_old),
    .wb_trap_o       (wb_trap)
  );

  csr_regfile u_csr_regfile (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .rd_port             (u_rd_if.regfile),
    .wb_port             (u_wb_if.regfile),
    .trap_handler_addr_o (trap_handler_addr_o)
  );

  csr_writeback u_csr_writeback (
    .wb_valid_i   (wb_valid),
    .wb_op_i      (wb_op),
    .wb_addr_i    (wb_addr),
    .wb_rd_i      (wb_rd),
    .wb_rs1_i     (wb_rs1),
    .wb_rs1_val_i (wb_rs1_val),
    .wb_old_i     (wb_old),
    .wb_trap_i    (wb_trap),
    .wb_port      (u_wb_if.writeback),
    .rd_we_o      (rd_we_o),
    .rd_addr_o    (rd_addr_o),
    .rd_wdata_o   (rd_wdata_o)
  );

endmodule

//--- sim/csr_subsys_tb.sv
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_subsys_tb;
  import csr_pkg::*;

  localparam int N_DIRECTED  = 9;
  localparam int N_RANDOM    = 600;
  localparam int N_DRAIN     = 4;
  localparam int TEST_CYCLES = 16 + N_DIRECTED + N_RANDOM + N_DRAIN;
  localparam int TIMEOUT_NS  = (TEST_CYCLES + 100) * 4;

  // one in-flight instruction as the model sees it
  typedef struct packed {
    logic      valid;
    logic      trap;
    logic      irq;
    cause_t    cause;
    xlen_t     pc;
    reg_idx_t  rd;
    logic      csr_we;
    csr_addr_t addr;
    xlen_t     wdata;
    xlen_t     old;
  } entry_t;

  logic clk_i, rst_i, issue_valid_i, issue_trap_valid_i, issue_trap_irq_i;
  csr_op_e   issue_op_i;
  csr_addr_t issue_addr_i;
  reg_idx_t  issue_rd_i, issue_rs1_i, rd_addr_o;
  xlen_t     issue_rs1_val_i, issue_trap_pc_i, rd_wdata_o, trap_handler_addr_o;
  cause_t    issue_trap_cause_i;
  logic      rd_we_o;

  // model state
  xlen_t  m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval;
  xlen_t  cyc_cnt, issued_cnt, mtvec_lag;
  entry_t inflight[$];

  csr_subsys_top u_csr_subsys_top (.*);

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  //////////////////////////////
  // checks and model
  //////////////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      $display("Finished with errors");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  function automatic xlen_t model_read(input csr_addr_t a);
    case (a)
      `CSR_ADDR_MTVEC:    return m_mtvec;
      `CSR_ADDR_MSCRATCH: return m_mscratch;
      `CSR_ADDR_MEPC:     return m_mepc;
      `CSR_ADDR_MCAUSE:   return m_mcause;
      `CSR_ADDR_MTVAL:    return m_mtval;
      `CSR_ADDR_MCYCLE:   return cyc_cnt;
      `CSR_ADDR_MINSTRET: return issued_cnt;
      // high halves stay 0 over a short run
      default:            return '0;
    endcase
  endfunction

  task automatic model_write(input csr_addr_t a, input xlen_t v);
    case (a)
      `CSR_ADDR_MTVEC:    m_mtvec    = {v[31:2], 2'b00};
      `CSR_ADDR_MSCRATCH: m_mscratch = v;
      `CSR_ADDR_MEPC:     m_mepc     = v;
      `CSR_ADDR_MCAUSE:   m_mcause   = v;
      `CSR_ADDR_MTVAL:    m_mtval    = v;
      default: ;
    endcase
  endtask

  function automatic csr_addr_t addr_by_index(input int i);
    case (i)
      0: return `CSR_ADDR_MTVEC;
      1: return `CSR_ADDR_MSCRATCH;
      2: return `CSR_ADDR_MEPC;
      3: return `CSR_ADDR_MCAUSE;
      4: return `CSR_ADDR_MTVAL;
      5: return `CSR_ADDR_MCYCLE;
      6: return `CSR_ADDR_MCYCLEH;
      7: return `CSR_ADDR_MINSTRET;
      default: return `CSR_ADDR_MINSTRETH;
    endcase
  endfunction

  function automatic csr_op_e op_by_index(input int i);
    case (i % 6)
      0: return CSR_RW;
      1: return CSR_RS;
      2: return CSR_RC;
      3: return CSR_RWI;
      4: return CSR_RSI;
      default: return CSR_RCI;
    endcase
  endfunction

  // one clock that checks the retiring entry, issues the next and retires it in the model
  task automatic run_cycle(input logic iv, input csr_op_e op, input csr_addr_t addr,
                           input reg_idx_t rd, input reg_idx_t rs1, input xlen_t rs1_val,
                           input logic tv, input logic irq, input cause_t cause,
                           input xlen_t pc);
    entry_t done;
    entry_t ent;
    xlen_t  src;
    @(posedge clk_i);
    #0.5;
    cyc_cnt = cyc_cnt + 1;
    check_value("trap_handler_addr_o", mtvec_lag, trap_handler_addr_o);
    mtvec_lag = m_mtvec;
    done = inflight.pop_front();
    if (done.valid && !done.trap) begin
      check_value("rd_we_o", 32'd1, 32'(rd_we_o));
      check_value("rd_addr_o", 32'(done.rd), 32'(rd_addr_o));
      check_value("rd_wdata_o", (done.rd == '0) ? 32'd0 : done.old, rd_wdata_o);
    end else begin
      check_value("rd_we_o", 32'd0, 32'(rd_we_o));
    end
    issue_valid_i      = iv;
    issue_op_i         = op;
    issue_addr_i       = addr;
    issue_rd_i         = rd;
    issue_rs1_i        = rs1;
    issue_rs1_val_i    = rs1_val;
    issue_trap_valid_i = tv;
    issue_trap_irq_i   = irq;
    issue_trap_cause_i = cause;
    issue_trap_pc_i    = pc;
    ent = '{valid: iv, trap: tv, irq: irq, cause: cause, pc: pc, rd: rd, csr_we: 1'b0,
            addr: addr, wdata: '0, old: model_read(addr)};
    src = (op == CSR_RWI || op == CSR_RSI || op == CSR_RCI) ? {27'd0, rs1} : rs1_val;
    case (op)
      CSR_RW, CSR_RWI: ent.wdata = src;
      CSR_RS, CSR_RSI: ent.wdata = ent.old | src;
      default:         ent.wdata = ent.old & ~src;
    endcase
    ent.csr_we = !tv && (op == CSR_RW || op == CSR_RWI || rs1 != '0);
    if (iv) issued_cnt = issued_cnt + 1;
    // the oldest entry reaches the edge that ends its write-back cycle
    if (done.valid && done.trap) begin
      m_mepc   = done.pc;
      m_mcause = {done.irq, done.cause};
    end else if (done.valid && done.csr_we) begin
      model_write(done.addr, done.wdata);
    end
    inflight.push_back(ent);
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    logic [31:0] r;
    logic [31:0] c32;
    int          a_idx;
    void'($urandom(32'h9c5b));
    rst_i = 1'b1;
    issue_valid_i = 1'b0;
    issue_op_i = CSR_RW;
    issue_addr_i = '0;
    issue_rd_i = '0;
    issue_rs1_i = '0;
    issue_rs1_val_i = '0;
    issue_trap_valid_i = 1'b0;
    issue_trap_irq_i = 1'b0;
    issue_trap_cause_i = '0;
    issue_trap_pc_i = '0;
    repeat (16) @(posedge clk_i);
    #0.5;
    rst_i = 1'b0;
    {m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval} = '0;
    {cyc_cnt, issued_cnt, mtvec_lag} = '0;
    repeat (3) inflight.push_back('0);
    check_value("rd_we_o", 32'd0, 32'(rd_we_o));

    // reset values by a plain read of every csr
    for (int i = 0; i < N_DIRECTED; i++) begin
      run_cycle(1'b1, CSR_RS, addr_by_index(i), 5'd1, 5'd0, $urandom(),
                1'b0, 1'b0, '0, '0);
    end

    for (int n = 0; n < N_RANDOM; n++) begin
      r = $urandom();
      c32 = $urandom();
      // counters drawn less often than trap registers
      a_idx = int'(r[23:20]) % 12;
      if (a_idx >= 9) a_idx = a_idx - 8;
      if (r[1:0] == 2'b00) begin
        run_cycle(1'b0, CSR_RW, '0, '0, '0, '0, 1'b0, 1'b0, '0, '0);
      end else begin
        run_cycle(1'b1, op_by_index(int'(r[19:16])), addr_by_index(a_idx),
                  (r[3:2] == 2'b00) ? 5'd0 : r[8:4],
                  (r[10:9] == 2'b00) ? 5'd0 : r[15:11],
                  $urandom(), r[26:24] == 3'd0, r[27], c32[30:0], $urandom());
      end
    end

    repeat (N_DRAIN) begin
      run_cycle(1'b0, CSR_RW, '0, '0, '0, '0, 1'b0, 1'b0, '0, '0);
    end
    $display("Finished with no errors");
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the test did not complete within %0d ns", TIMEOUT_NS);
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- csr_unit.f
+incdir+include
verilog/csr_pkg.sv
verilog/csr_ifs.sv
verilog/csr_regfile.sv
verilog/csr_pipe.sv
verilog/csr_writeback.sv
verilog/csr_subsys_top.sv
sim/csr_subsys_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module csr_subsys_tb \
		-f csr_unit.f -Mdir obj_dir
	./obj_dir/Vcsr_subsys_tb | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
